/* compile.f */
+incdir+source
source/exec_op_pkg.sv
source/exec_bus_pkg.sv
source/ieu_au.sv
source/ieu_lu.sv
source/ieu_mu.sv
source/ieu.sv
sim/ieu_tb_mem.sv
sim/ieu_tb.sv

/* sim/ieu_input.txt */
// Columns: ctrl op1 op2 op3 pc spec tgt exp_wb exp_tgt exp_flush, all hex
// ctrl digits: au, lu(2), mem {sext,store,load}, size, {link,wb}, reg(2); spec: jmprel jmpfar bcc cc
// A lone ffffffff ends the list
00100101 f0f01234 0ff0ff00 0 0 0 0 00f01200 0 0
00200102 f0f01234 0ff0ff00 0 0 0 0 fff0ff34 0 0
00400103 f0f01234 0ff0ff00 0 0 0 0 ff00ed34 0 0
00800104 80000001 00000104 0 0 0 0 00000010 0 0
01000105 80000001 0000003f 0 0 0 0 00000001 0 0
02000106 80000001 00000004 0 0 0 0 f8000000 0 0
02000107 7ffffff0 00000008 0 0 0 0 007fffff 0 0
00800108 12345678 ffffffe0 0 0 0 0 12345678 0 0
10000109 7fffffff 00000001 0 0 0 0 80000000 0 0
1000010a ffffffff 00000002 0 0 0 0 00000001 0 0
2000010b 00000005 00000007 0 0 0 0 fffffffe 0 0
2000010c 12345678 02345670 0 0 0 0 10000008 0 0
0000030d 0 0 0 00000100 0 0 00000404 0 0
0000030e 0 0 0 3fffffff 0 0 00000000 0 0
00024000 00000100 00000000 a1b2c3d4 0 0 0 0 0 0
00022000 00000100 00000006 ffff8765 0 0 0 0 0 0
00021000 00000100 00000004 000000f7 0 0 0 0 0 0
00021000 00000100 00000005 0000007e 0 0 0 0 0 0
00014110 00000100 00000000 0 0 0 0 a1b2c3d4 0 0
00011111 00000100 00000000 0 0 0 0 000000d4 0 0
00051112 00000100 00000000 0 0 0 0 ffffffd4 0 0
00051113 00000100 00000003 0 0 0 0 ffffffa1 0 0
00011114 00000100 00000005 0 0 0 0 0000007e 0 0
00012115 00000100 00000000 0 0 0 0 0000c3d4 0 0
00052116 00000100 00000002 0 0 0 0 ffffa1b2 0 0
00052117 00000100 00000006 0 0 0 0 ffff8765 0 0
00012118 00000100 00000004 0 0 0 0 00007ef7 0 0
00014119 00000108 fffffffc 0 0 0 0 87657ef7 0 0
00000000 0 0 0 00000020 1011 00000040 0 0 0
00000000 0 0 0 00000020 1010 00000040 0 00000040 1
00000000 0 0 0 00000020 1001 00000123 0 00000123 1
00000000 0 0 0 00000020 1000 00000077 0 0 0
00000000 00000200 0 0 00000030 0100 00000200 0 0 0
00000000 e0000200 0 0 00000030 0100 20000200 0 0 0
00000000 00000300 0 0 00000030 0100 00000200 0 00000300 1
0000031f 00000080 0 0 00000010 0100 00000090 00000044 00000080 1
ffffffff

/* sim/ieu_tb.sv */
// Testbench for the execution unit, replays the vectors of sim/ieu_input.txt and checks results
`timescale 1ns/1ps
`include "exec_config.svh"

module ieu_tb;

   localparam int NWORDS = 10;   // Hex words per vector line
   localparam int MAXVEC = 64;
   localparam int TDRV   = 2;    // Drive delay after the rising edge

   logic [31:0] vec_mem [0:NWORDS*MAXVEC-1];
   int          num_vec;
   logic        vec_ready;       // Vector count known, watchdog may start
   int          err_cnt;
   int          chk_cnt;
   int          fail_cnt;

   logic                      clk;
   logic                      rst_n_i;
   logic                      in_valid_i, in_ready_o;
   exec_op_pkg::word_t        operand_1_i, operand_2_i, operand_3_i;
   exec_op_pkg::au_opc_t      au_opc_i;
   exec_op_pkg::lu_opc_t      lu_opc_i;
   logic                      mu_load_i, mu_store_i, mu_sign_ext_i;
   exec_bus_pkg::mem_size_t   mu_size_i;
   logic                      wb_regf_i, jmplink_i;
   exec_op_pkg::reg_addr_t    wb_reg_addr_i;
   exec_op_pkg::pc_t          insn_pc_i, specul_tgt_i;
   logic                      specul_jmprel_i, specul_jmpfar_i, specul_bcc_i, psr_cc_i;
   exec_bus_pkg::bus_addr_t   dbus_addr_o;
   exec_op_pkg::word_t        dbus_data_o, dbus_i;
   exec_bus_pkg::mem_size_t   dbus_size_o;
   logic                      dbus_we_o, dbus_in_valid_o, dbus_in_ready_i;
   logic                      dbus_out_valid_i, dbus_out_ready_o;
   logic                      regf_we_o;
   exec_op_pkg::reg_addr_t    regf_addr_o;
   exec_op_pkg::word_t        regf_din_o;
   logic                      specul_flush_o, bpu_wb_o, bpu_wb_jmprel_o, bpu_wb_hit_o;
   exec_op_pkg::pc_t          flush_tgt_o, bpu_wb_pc_o;

   ieu UUT (.clk_i(clk), .*);

   // Bus side is answered by the memory model
   ieu_tb_mem mem_model (
      .clk_i       (clk),
      .rst_n_i     (rst_n_i),
      .addr_i      (dbus_addr_o),
      .data_i      (dbus_data_o),
      .size_i      (dbus_size_o),
      .we_i        (dbus_we_o),
      .in_valid_i  (dbus_in_valid_o),
      .in_ready_o  (dbus_in_ready_i),
      .out_valid_o (dbus_out_valid_i),
      .data_o      (dbus_i),
      .out_ready_i (dbus_out_ready_o)
   );

   initial clk = 1'b0;
   always #10 clk = ~clk;          // 20 ns period

   task automatic check_word(input string name, input exec_op_pkg::word_t exp,
                             input exec_op_pkg::word_t got);
      chk_cnt++;
      if (got !== exp) begin
         $display("FAILED %s exp %h got %h", name, exp, got);
         err_cnt++;
      end
   endtask

   task automatic check_pc(input string name, input exec_op_pkg::pc_t exp,
                           input exec_op_pkg::pc_t got);
      chk_cnt++;
      if (got !== exp) begin
         $display("FAILED %s exp %h got %h", name, exp, got);
         err_cnt++;
      end
   endtask

   task automatic check_reg(input string name, input exec_op_pkg::reg_addr_t exp,
                            input exec_op_pkg::reg_addr_t got);
      chk_cnt++;
      if (got !== exp) begin
         $display("FAILED %s exp %h got %h", name, exp, got);
         err_cnt++;
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic got);
      chk_cnt++;
      if (got !== exp) begin
         $display("FAILED %s exp %h got %h", name, exp, got);
         err_cnt++;
      end
   endtask

   // Idle values on every upstream input
   task automatic clear_inputs();
      in_valid_i      = 1'b0;
      {operand_1_i, operand_2_i, operand_3_i} = '0;
      au_opc_i        = '0;
      lu_opc_i        = '0;
      {mu_load_i, mu_store_i, mu_sign_ext_i} = '0;
      mu_size_i       = '0;
      {wb_regf_i, jmplink_i} = '0;
      wb_reg_addr_i   = '0;
      insn_pc_i       = '0;
      specul_tgt_i    = '0;
      {specul_jmprel_i, specul_jmpfar_i, specul_bcc_i, psr_cc_i} = '0;
   endtask

   // Unpack one vector line onto the upstream port
   task automatic apply_vector(input int v);
      logic [31:0] ctrl;
      logic [31:0] spec;
      ctrl            = vec_mem[v*NWORDS];
      spec            = vec_mem[v*NWORDS+5];
      au_opc_i        = ctrl[29:28];
      lu_opc_i        = ctrl[25:20];
      mu_load_i       = ctrl[16];
      mu_store_i      = ctrl[17];
      mu_sign_ext_i   = ctrl[18];
      mu_size_i       = ctrl[14:12];
      jmplink_i       = ctrl[9];
      wb_regf_i       = ctrl[8];
      wb_reg_addr_i   = ctrl[4:0];
      operand_1_i     = vec_mem[v*NWORDS+1];
      operand_2_i     = vec_mem[v*NWORDS+2];
      operand_3_i     = vec_mem[v*NWORDS+3];   // Store data
      insn_pc_i       = vec_mem[v*NWORDS+4][`EXEC_PCW-1:0];
      specul_jmprel_i = spec[12];
      specul_jmpfar_i = spec[8];
      specul_bcc_i    = spec[4];
      psr_cc_i        = spec[0];
      specul_tgt_i    = vec_mem[v*NWORDS+6][`EXEC_PCW-1:0];
      in_valid_i      = 1'b1;
   endtask

   // Watchdog, 64 cycles per test
   initial begin
      wait (vec_ready === 1'b1);
      repeat ((num_vec + 1) * 64) @(posedge clk);
      $display("Timeout after %0d cycles, an instruction never retired", (num_vec + 1) * 64);
      $display("SIMULATION FAILED");
      $finish;
   end

   initial begin
      int                     v;
      int                     we_cnt;
      int                     start_err;
      logic                   exp_flush;
      exec_op_pkg::word_t     wb_seen;
      exec_op_pkg::reg_addr_t addr_seen;
      clear_inputs();
      rst_n_i   = 1'b0;
      vec_ready = 1'b0;
      err_cnt   = 0;
      chk_cnt   = 0;
      fail_cnt  = 0;
      $readmemh("sim/ieu_input.txt", vec_mem);
      num_vec = 0;
      while (num_vec < MAXVEC && vec_mem[num_vec*NWORDS] !== 32'hffffffff) begin
         num_vec++;
      end
      vec_ready = 1'b1;
      repeat (16) @(posedge clk);
      #TDRV rst_n_i = 1'b1;

      // Nothing moves without a valid insn
      start_err = err_cnt;
      repeat (4) begin
         @(negedge clk);
         check_bit("dbus_in_valid_o", 1'b0, dbus_in_valid_o);
         check_bit("dbus_out_ready_o", 1'b0, dbus_out_ready_o);
         check_bit("regf_we_o", 1'b0, regf_we_o);
      end
      if (err_cnt != start_err) fail_cnt++;
      $display("test idle after reset: %s", (err_cnt == start_err) ? "ok" : "errors");

      for (v = 0; v < num_vec; v++) begin
         start_err = err_cnt;
         we_cnt    = 0;
         exp_flush = vec_mem[v*NWORDS+9][0];
         @(posedge clk);
         #TDRV apply_vector(v);
         @(negedge clk);
         // Speculation outputs hold while in_valid_i is high
         check_bit("specul_flush_o", exp_flush, specul_flush_o);
         check_bit("bpu_wb_hit_o", ~exp_flush, bpu_wb_hit_o);
         check_bit("bpu_wb_o", specul_jmprel_i | specul_jmpfar_i, bpu_wb_o);
         check_bit("bpu_wb_jmprel_o", specul_jmprel_i, bpu_wb_jmprel_o);
         if (specul_jmprel_i | specul_jmpfar_i) begin
            check_pc("bpu_wb_pc_o", vec_mem[v*NWORDS+4][`EXEC_PCW-1:0], bpu_wb_pc_o);
         end
         if (exp_flush) check_pc("flush_tgt_o", vec_mem[v*NWORDS+8][`EXEC_PCW-1:0], flush_tgt_o);
         forever begin
            if (regf_we_o) begin
               we_cnt++;
               wb_seen   = regf_din_o;
               addr_seen = regf_addr_o;
            end
            if (in_ready_o) break;
            @(negedge clk);
         end
         @(posedge clk);
         #TDRV clear_inputs();
         @(negedge clk);
         if (regf_we_o) we_cnt++;    // Stray pulse after retire
         if (vec_mem[v*NWORDS][8]) begin
            if (we_cnt == 0) begin
               $display("Vector %0d wrote no register, regf_we_o never went high", v);
               err_cnt++;
            end else if (we_cnt > 1) begin
               $display("Vector %0d pulsed regf_we_o %0d times instead of once", v, we_cnt);
               err_cnt++;
            end else begin
               check_word("regf_din_o", vec_mem[v*NWORDS+7], wb_seen);
               check_reg("regf_addr_o", vec_mem[v*NWORDS][`EXEC_REG_AW-1:0], addr_seen);
            end
         end else if (we_cnt != 0) begin
            $display("Vector %0d wrote a register although it has no write-back", v);
            err_cnt++;
         end
         if (err_cnt != start_err) fail_cnt++;
         $display("test vector %0d: %s", v, (err_cnt == start_err) ? "ok" : "errors");
      end

      $display("%0d tests, %0d failed, %0d checks, %0d errors",
               num_vec + 1, fail_cnt, chk_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

/* sim/ieu_tb_mem.sv */
// Data-bus memory model for the execution unit testbench, stalls requests and load data at random
`timescale 1ns/1ps
`include "exec_config.svh"

module ieu_tb_mem (
   input  logic                      clk_i,
   input  logic                      rst_n_i,
   input  exec_bus_pkg::bus_addr_t   addr_i,
   input  exec_op_pkg::word_t        data_i,      // Store data in its lanes
   input  exec_bus_pkg::mem_size_t   size_i,
   input  logic                      we_i,
   input  logic                      in_valid_i,
   output logic                      in_ready_o,
   output logic                      out_valid_o,
   output exec_op_pkg::word_t        data_o,      // Aligned load word
   input  logic                      out_ready_i
);

   localparam int MEM_AW = 10;                      // 1 KiB of bytes

   logic [`EXEC_BW-1:0] mem [0:(1<<MEM_AW)-1];
   integer              seed;
   logic                pending;                   // Load accepted, data not yet taken

   initial begin
      seed        = 32'hb64f;
      pending     = 1'b0;
      in_ready_o  = 1'b0;
      out_valid_o = 1'b0;
      data_o      = '0;
      for (int i = 0; i < (1<<MEM_AW); i++) begin
         mem[i] = 8'(i * 37) ^ 8'(i >> 8);       // Every address bit shows up
      end
   end

   always @(posedge clk_i) begin
      logic                    accept;
      logic                    taken;
      logic                    rst_seen;
      logic                    we;
      logic [MEM_AW-1:0]       a;
      logic [1:0]              off;
      int                      nbytes;
      exec_op_pkg::word_t      wdata;
      logic [31:0]             rnd;
      // Sample at the edge, act after the drive delay
      accept   = in_valid_i & in_ready_o;
      taken    = out_valid_o & out_ready_i;
      rst_seen = ~rst_n_i;
      we       = we_i;
      a        = {addr_i[MEM_AW-1:2], 2'b00};
      off      = addr_i[1:0];
      wdata    = data_i;
      nbytes   = (size_i == 3'd1) ? 1 : (size_i == 3'd2) ? 2 : 4;
      #2;
      if (rst_seen) begin
         in_ready_o  = 1'b0;
         out_valid_o = 1'b0;
         pending     = 1'b0;
      end else begin
         if (accept && we) begin
            for (int b = 0; b < 4; b++) begin
               if (b >= off && b < off + nbytes) mem[a + b] = wdata[8*b +: 8];
            end
         end
         if (accept && !we) begin
            pending = 1'b1;
            data_o  = {mem[a + 3], mem[a + 2], mem[a + 1], mem[a]};   // Little-endian
         end
         rnd = $random(seed);
         if (taken) begin
            out_valid_o = 1'b0;
            pending     = 1'b0;
         end else if (pending && !out_valid_o) begin
            out_valid_o = rnd[1];                  // Once up, held until taken
         end
         in_ready_o = rnd[0];
      end
   end

endmodule

/* source/exec_bus_pkg.sv */
// Data-bus types shared by the memory unit and the testbench memory model
`include "exec_config.svh"

package exec_bus_pkg;

   // Access size, number of bytes in the transfer
   typedef logic [2:0] mem_size_t;

   localparam mem_size_t SIZE_BYTE = 3'd1;   // 8 bit access
   localparam mem_size_t SIZE_HALF = 3'd2;   // 16 bit access
   localparam mem_size_t SIZE_WORD = 3'd4;   // Full word

   // Other encodings are treated as a word

   // Byte address on the data bus
   typedef logic [`EXEC_AW-1:0] bus_addr_t;

   // Lane order is little-endian
   // Address bits [1:0] pick the lowest lane of the access
   // Halves sit on lane 0 or 2, bytes on any lane

endpackage

/* source/exec_config.svh */
// Width macros for the execution unit, included by every RTL file and the testbench
`ifndef EXEC_CONFIG_SVH
`define EXEC_CONFIG_SVH

// Data path width in bits
`define EXEC_DW 32

// Byte address width on the data bus
`define EXEC_AW 32

// Register file index width, 32 registers
`define EXEC_REG_AW 5

// Instruction word address, byte address without its two low bits
`define EXEC_PCW (`EXEC_AW-2)

// Shift amount taken from operand 2
`define EXEC_SHW 5

// Bits per byte lane
`define EXEC_BW 8

`endif

/* source/exec_op_pkg.sv */
// Operand and opcode types of the execution unit, referenced by scoped name from each block
`include "exec_config.svh"

package exec_op_pkg;

   // Data word as seen by all units
   typedef logic [`EXEC_DW-1:0] word_t;

   // Word address of an instruction
   typedef logic [`EXEC_PCW-1:0] pc_t;

   // Destination register index
   typedef logic [`EXEC_REG_AW-1:0] reg_addr_t;

   // Arithmetic opcode bus, one-hot
   // Bit 0 add, bit 1 sub
   typedef struct packed {
      logic op_sub;    // Bit 1
      logic op_add;    // Bit 0
   } au_opc_t;

   // Logic opcode bus, one-hot
   // Bit 0 and up to bit 5 sra
   typedef struct packed {
      logic op_sra;    // Bit 5, arithmetic right
      logic op_srl;    // Bit 4, logical right
      logic op_sll;    // Bit 3, logical left
      logic op_xor;    // Bit 2
      logic op_or;     // Bit 1
      logic op_and;    // Bit 0
   } lu_opc_t;

   // Never more than one bit set across both buses

endpackage

/* source/ieu.sv */
// Integer execution unit top, takes one decoded insn from issue and commits it to the regfile
`timescale 1ns/1ps
`include "exec_config.svh"

module ieu (
   input  logic                        clk_i,
   input  logic                        rst_n_i,
   // Upstream insn
   input  logic                        in_valid_i,
   output logic                        in_ready_o,     // Insn retires this cycle
   input  exec_op_pkg::word_t          operand_1_i,
   input  exec_op_pkg::word_t          operand_2_i,
   input  exec_op_pkg::word_t          operand_3_i,    // Store data
   input  exec_op_pkg::au_opc_t        au_opc_i,
   input  exec_op_pkg::lu_opc_t        lu_opc_i,
   input  logic                        mu_load_i,
   input  logic                        mu_store_i,
   input  logic                        mu_sign_ext_i,
   input  exec_bus_pkg::mem_size_t     mu_size_i,
   input  logic                        wb_regf_i,      // Insn writes a register
   input  exec_op_pkg::reg_addr_t      wb_reg_addr_i,
   input  logic                        jmplink_i,
   input  exec_op_pkg::pc_t            insn_pc_i,
   input  logic                        specul_jmprel_i,
   input  logic                        specul_jmpfar_i,
   input  logic                        specul_bcc_i,   // Predicted condition
   input  exec_op_pkg::pc_t            specul_tgt_i,   // Predicted target
   input  logic                        psr_cc_i,       // Actual condition flag
   // Data bus
   output exec_bus_pkg::bus_addr_t     dbus_addr_o,
   output exec_op_pkg::word_t          dbus_data_o,
   output exec_bus_pkg::mem_size_t     dbus_size_o,
   output logic                        dbus_we_o,
   output logic                        dbus_in_valid_o,
   input  logic                        dbus_in_ready_i,
   input  logic                        dbus_out_valid_i,
   input  exec_op_pkg::word_t          dbus_i,
   output logic                        dbus_out_ready_o,
   // Register file write port
   output logic                        regf_we_o,
   output exec_op_pkg::reg_addr_t      regf_addr_o,
   output exec_op_pkg::word_t          regf_din_o,
   // Fetch and predictor
   output logic                        specul_flush_o,
   output exec_op_pkg::pc_t            flush_tgt_o,
   output logic                        bpu_wb_o,
   output logic                        bpu_wb_jmprel_o,
   output logic                        bpu_wb_hit_o,
   output exec_op_pkg::pc_t            bpu_wb_pc_o
);

   exec_op_pkg::word_t au_adder;
   logic               au_op_adder;
   exec_op_pkg::word_t lu_and;
   exec_op_pkg::word_t lu_or;
   exec_op_pkg::word_t lu_xor;
   exec_op_pkg::word_t lu_shift;
   logic               lu_op_shift;
   exec_op_pkg::word_t mu_load_data;
   logic               mu_done;
   logic               mu_req;
   logic               mem_op;         // Load or store in flight
   exec_op_pkg::pc_t   pc_next;        // Insn after the jump
   exec_op_pkg::word_t link_addr;
   logic               jmprel_miss;
   logic               jmpfar_miss;

   ieu_au au (
      .a_i        (operand_1_i),
      .b_i        (operand_2_i),
      .opc_i      (au_opc_i),
      .adder_o    (au_adder),
      .op_adder_o (au_op_adder)
   );

   ieu_lu lu (
      .a_i        (operand_1_i),
      .b_i        (operand_2_i),
      .opc_i      (lu_opc_i),
      .and_o      (lu_and),
      .or_o       (lu_or),
      .xor_o      (lu_xor),
      .shift_o    (lu_shift),
      .op_shift_o (lu_op_shift)
   );

   assign mem_op = mu_load_i | mu_store_i;
   assign mu_req = in_valid_i & mem_op;

   ieu_mu mu (
      .clk_i            (clk_i),
      .rst_n_i          (rst_n_i),
      .req_i            (mu_req),
      .load_i           (mu_load_i),
      .store_i          (mu_store_i),
      .sign_ext_i       (mu_sign_ext_i),
      .size_i           (mu_size_i),
      .base_i           (operand_1_i),
      .offset_i         (operand_2_i),
      .store_data_i     (operand_3_i),
      .done_o           (mu_done),
      .load_data_o      (mu_load_data),
      .dbus_addr_o      (dbus_addr_o),
      .dbus_data_o      (dbus_data_o),
      .dbus_size_o      (dbus_size_o),
      .dbus_we_o        (dbus_we_o),
      .dbus_in_valid_o  (dbus_in_valid_o),
      .dbus_in_ready_i  (dbus_in_ready_i),
      .dbus_out_valid_i (dbus_out_valid_i),
      .dbus_i           (dbus_i),
      .dbus_out_ready_o (dbus_out_ready_o)
   );

   // Link address as a byte address, (pc + 1) * 4
   assign pc_next   = insn_pc_i + exec_op_pkg::pc_t'(1);
   assign link_addr = {pc_next, 2'b00};

   // One-hot selects, at most one term is non-zero
   assign regf_din_o = ({`EXEC_DW{lu_opc_i.op_and}} & lu_and)       |
                       ({`EXEC_DW{lu_opc_i.op_or}}  & lu_or)        |
                       ({`EXEC_DW{lu_opc_i.op_xor}} & lu_xor)       |
                       ({`EXEC_DW{lu_op_shift}}     & lu_shift)     |
                       ({`EXEC_DW{au_op_adder}}     & au_adder)     |
                       ({`EXEC_DW{mu_load_i}}       & mu_load_data) |
                       ({`EXEC_DW{jmplink_i}}       & link_addr);

   // ALU insns retire at once, memory insns on the done pulse
   assign in_ready_o  = ~mem_op | mu_done;
   assign regf_we_o   = in_valid_i & in_ready_o & wb_regf_i;
   assign regf_addr_o = wb_reg_addr_i;

   // Mispredicted condition or target
   assign jmprel_miss = specul_jmprel_i & (specul_bcc_i != psr_cc_i);
   assign jmpfar_miss = specul_jmpfar_i & (specul_tgt_i != operand_1_i[`EXEC_PCW-1:0]);

   assign specul_flush_o = in_valid_i & (jmprel_miss | jmpfar_miss);
   assign flush_tgt_o    = specul_jmprel_i ? specul_tgt_i : operand_1_i[`EXEC_PCW-1:0];

   // Predictor update for both jump kinds
   assign bpu_wb_o        = in_valid_i & (specul_jmprel_i | specul_jmpfar_i);
   assign bpu_wb_jmprel_o = in_valid_i & specul_jmprel_i;
   assign bpu_wb_hit_o    = ~specul_flush_o;
   assign bpu_wb_pc_o     = insn_pc_i;

endmodule

/* source/ieu_au.sv */
// Arithmetic unit of the execution unit, instantiated by ieu for add and subtract
`timescale 1ns/1ps
`include "exec_config.svh"

module ieu_au (
   input  exec_op_pkg::word_t   a_i,         // Operand 1
   input  exec_op_pkg::word_t   b_i,         // Operand 2
   input  exec_op_pkg::au_opc_t opc_i,       // One-hot opcode
   output exec_op_pkg::word_t   adder_o,     // Sum or difference
   output logic                 op_adder_o   // Adder result selected
);

   exec_op_pkg::word_t b_mux;     // b or its complement
   logic               carry_in;
   logic [`EXEC_DW:0]  sum_ext;   // Extra top bit holds the carry out

   // Subtract as a + ~b + 1
   assign carry_in = opc_i.op_sub;

   always_comb begin
      if (opc_i.op_sub) begin
         b_mux = ~b_i;
      end else begin
         b_mux = b_i;
      end
   end

   // Single adder shared by both opcodes
   assign sum_ext = {1'b0, a_i} + {1'b0, b_mux} + {{`EXEC_DW{1'b0}}, carry_in};

   assign adder_o = sum_ext[`EXEC_DW-1:0];   // Modulo 2^32, carry dropped

   // Write-back select
   assign op_adder_o = opc_i.op_add | opc_i.op_sub;

endmodule

/* source/ieu_lu.sv */
// Logic unit of the execution unit, instantiated by ieu for bitwise and shift opcodes
`timescale 1ns/1ps
`include "exec_config.svh"

module ieu_lu (
   input  exec_op_pkg::word_t   a_i,        // Value to operate on
   input  exec_op_pkg::word_t   b_i,        // Second operand, shift amount in low bits
   input  exec_op_pkg::lu_opc_t opc_i,      // One-hot opcode
   output exec_op_pkg::word_t   and_o,
   output exec_op_pkg::word_t   or_o,
   output exec_op_pkg::word_t   xor_o,
   output exec_op_pkg::word_t   shift_o,    // Result of any shift
   output logic                 op_shift_o  // Shift result selected
);

   logic [`EXEC_SHW-1:0]   shamt;
   logic                   fill;           // Bit shifted in from the top
   exec_op_pkg::word_t     sh_in;          // Shifter input, reversed for sll
   logic [2*`EXEC_DW-1:0]  sh_ext;         // Fill bits above the data
   exec_op_pkg::word_t     sh_right;       // Right-shifted result

   // Mirror a word end to end
   function automatic exec_op_pkg::word_t bit_rev(input exec_op_pkg::word_t w);
      exec_op_pkg::word_t r;
      for (int i = 0; i < `EXEC_DW; i++) begin
         r[i] = w[`EXEC_DW-1-i];
      end
      return r;
   endfunction

   // Bitwise results
   assign and_o = a_i & b_i;
   assign or_o  = a_i | b_i;
   assign xor_o = a_i ^ b_i;

   assign shamt = b_i[`EXEC_SHW-1:0];      // Only five bits count

   // Sign fill only for sra
   assign fill = opc_i.op_sra & a_i[`EXEC_DW-1];

   // Left shift is a right shift of the mirrored word
   assign sh_in = opc_i.op_sll ? bit_rev(a_i) : a_i;

   assign sh_ext   = {{`EXEC_DW{fill}}, sh_in} >> shamt;
   assign sh_right = sh_ext[`EXEC_DW-1:0];

   // Mirror back for sll
   assign shift_o = opc_i.op_sll ? bit_rev(sh_right) : sh_right;

   assign op_shift_o = opc_i.op_sll | opc_i.op_srl | opc_i.op_sra;

endmodule

/* source/ieu_mu.sv */
// Memory unit of the execution unit, runs one load or store over the data bus for ieu
`timescale 1ns/1ps
`include "exec_config.svh"

module ieu_mu (
   input  logic                      clk_i,
   input  logic                      rst_n_i,
   input  logic                      req_i,          // Memory insn valid upstream
   input  logic                      load_i,
   input  logic                      store_i,
   input  logic                      sign_ext_i,     // Sign extend loaded value
   input  exec_bus_pkg::mem_size_t   size_i,
   input  exec_op_pkg::word_t        base_i,         // Operand 1
   input  exec_op_pkg::word_t        offset_i,       // Operand 2
   input  exec_op_pkg::word_t        store_data_i,   // Operand 3
   output logic                      done_o,         // One cycle completion pulse
   output exec_op_pkg::word_t        load_data_o,    // Aligned and extended
   output exec_bus_pkg::bus_addr_t   dbus_addr_o,
   output exec_op_pkg::word_t        dbus_data_o,    // Store data in its lanes
   output exec_bus_pkg::mem_size_t   dbus_size_o,
   output logic                      dbus_we_o,      // High for a store
   output logic                      dbus_in_valid_o,
   input  logic                      dbus_in_ready_i,
   input  logic                      dbus_out_valid_i,
   input  exec_op_pkg::word_t        dbus_i,         // Load data from the bus
   output logic                      dbus_out_ready_o
);

   typedef enum logic [1:0] {
      S_IDLE,    // Waiting for a request
      S_REQ,     // Request presented on the bus
      S_RESP,    // Load waiting for data
      S_DONE     // Completion cycle
   } state_t;

   state_t                    state_q;
   state_t                    state_d;
   exec_bus_pkg::bus_addr_t   addr_q;
   exec_bus_pkg::mem_size_t   size_q;
   exec_op_pkg::word_t        wdata_q;
   exec_op_pkg::word_t        wdata_lanes;   // Store data replicated over lanes
   exec_op_pkg::word_t        rdata_q;       // Raw word captured from the bus
   exec_op_pkg::word_t        rdata_lane;    // Addressed lane moved to bit 0
   logic                      we_q;
   logic                      capture;       // Register a new request

   // Replicate narrow store data so every lane carries it
   always_comb begin
      case (size_i)
         exec_bus_pkg::SIZE_BYTE: wdata_lanes = {(`EXEC_DW/8){store_data_i[7:0]}};
         exec_bus_pkg::SIZE_HALF: wdata_lanes = {(`EXEC_DW/16){store_data_i[15:0]}};
         default:                 wdata_lanes = store_data_i;
      endcase
   end

   assign capture = (state_q == S_IDLE) & req_i & (load_i | store_i);

   // Sequencer
   always_comb begin
      state_d = state_q;
      case (state_q)
         S_IDLE: if (capture) state_d = S_REQ;
         S_REQ: begin
            if (dbus_in_ready_i) begin
               state_d = we_q ? S_DONE : S_RESP;   // Store has no response
            end
         end
         S_RESP: if (dbus_out_valid_i) state_d = S_DONE;
         default: state_d = S_IDLE;                // Done lasts one cycle
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         state_q <= S_IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   // Request payload, held for the whole access
   always_ff @(posedge clk_i) begin
      if (capture) begin
         addr_q  <= base_i + offset_i;
         size_q  <= size_i;
         wdata_q <= wdata_lanes;
         we_q    <= store_i;
      end
      if ((state_q == S_RESP) && dbus_out_valid_i) begin
         rdata_q <= dbus_i;   // Load data lands here
      end
   end

   // Move the addressed lane down, little-endian
   assign rdata_lane = rdata_q >> {addr_q[1:0], 3'b000};

   always_comb begin
      case (size_q)
         exec_bus_pkg::SIZE_BYTE: begin
            load_data_o = {{(`EXEC_DW-`EXEC_BW){sign_ext_i & rdata_lane[`EXEC_BW-1]}},
                           rdata_lane[`EXEC_BW-1:0]};
         end
         exec_bus_pkg::SIZE_HALF: begin
            load_data_o = {{(`EXEC_DW-2*`EXEC_BW){sign_ext_i & rdata_lane[2*`EXEC_BW-1]}},
                           rdata_lane[2*`EXEC_BW-1:0]};
         end
         default: load_data_o = rdata_lane;       // Word, lane offset is zero
      endcase
   end

   // Bus side
   assign dbus_addr_o      = addr_q;
   assign dbus_data_o      = wdata_q;
   assign dbus_size_o      = size_q;
   assign dbus_we_o        = we_q;
   assign dbus_in_valid_o  = (state_q == S_REQ);    // Held until accepted
   assign dbus_out_ready_o = (state_q == S_RESP);

   assign done_o = (state_q == S_DONE);

endmodule
